//--- vlog.f
lsi_bus_pkg.sv
lsi_ctl_pkg.sv
lsi_cmd_queue.sv
lsi_bus_master.sv
lsi_sys_ctl.sv
lsi_bus_top.sv
tb_wb_slave.sv
tb_lsi_bus.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the LSI-11 bus testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_lsi_bus -f vlog.f -o tb_lsi_bus_sim
./obj_dir/tb_lsi_bus_sim

//--- tb_lsi_bus.sv
// --------------------------------------------------
// LSI-11 bus interface testbench
// Credit-counting command driver, stimulus table,
// in-order response checks against a memory model
// --------------------------------------------------
`timescale 1ns/1ps

module tb_lsi_bus;

   typedef struct packed {
      lsi_ctl_pkg::cmd_op_e   op;
      lsi_ctl_pkg::sys_code_e code;                   // OP_SYS only
      logic [15:0]            adr;
      logic [15:0]            dat;                    // write data or vector
      logic                   drain;                  // drain before the status check
      logic [5:0]             pins;                   // aclo evnt halt virq bsel
      logic [4:0]             chk;                    // init irq[3:1] berr
   } step_t;

   logic                  vm_clk_p;
   logic                  m_sr;
   logic                  cmd_valid;
   lsi_ctl_pkg::cmd_t     cmd;
   logic                  credit;
   logic                  rsp_valid;
   lsi_ctl_pkg::rsp_t     rsp;
   logic                  wbm_gnt;
   lsi_bus_pkg::wb_req_t  wbm_req;
   lsi_bus_pkg::wb_rsp_t  wbm_rsp;
   logic                  wbi_stb;
   lsi_bus_pkg::vec_rsp_t wbi_rsp;
   logic [5:0]            pins;                       // system inputs
   logic                  init;
   logic [3:1]            irq;
   logic                  berr;
   logic [15:0]           vector;                     // slave vector

   step_t             steps [$];
   lsi_ctl_pkg::rsp_t exp_q [$];                      // responses still due
   lsi_ctl_pkg::rsp_t exp_rsp;
   logic [15:0]       model [64];                     // memory model
   int                credits;
   int                sent;
   int                returned;
   logic              aclo_rq_m;                      // request flag models
   logic              berr_m;
   logic              fdin_m;

   lsi_bus_top UUT
   (
      .vm_clk_p (vm_clk_p), .m_sr (m_sr),
      .cmd_valid_i (cmd_valid), .cmd_i (cmd), .credit_o (credit),
      .rsp_valid_o (rsp_valid), .rsp_o (rsp),
      .wbm_gnt_i (wbm_gnt), .wbm_req_o (wbm_req), .wbm_rsp_i (wbm_rsp),
      .wbi_stb_o (wbi_stb), .wbi_rsp_i (wbi_rsp),
      .vm_aclo_i (pins[5]), .vm_evnt_i (pins[4]), .vm_halt_i (pins[3]),
      .vm_virq_i (pins[2]), .vm_bsel_i (pins[1:0]),
      .init_o (init), .irq_o (irq), .berr_o (berr)
   );

   tb_wb_slave u_slave
   (
      .vm_clk_p (vm_clk_p), .m_sr (m_sr),
      .wbm_req_i (wbm_req), .wbm_rsp_o (wbm_rsp),
      .wbi_stb_i (wbi_stb), .vec_i (vector), .wbi_rsp_o (wbi_rsp)
   );

   initial
   begin
      vm_clk_p = 1'b0;
      forever #4 vm_clk_p = ~vm_clk_p;                // 8 ns period
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1, "stopped at the first failure");
   endtask

   // one falling edge with credit collection
   task automatic tick();
      @(negedge vm_clk_p);
      if (credit)
      begin
         credits++;
         returned++;
      end
      assert (credits <= lsi_ctl_pkg::CMD_CREDITS)
         else fail_run($sformatf("ERR %0t: credit count %0d above limit", $time, credits));
   endtask

   task automatic check_status(input logic [4:0] chk);
      assert ({init, irq, berr} == chk)
         else fail_run($sformatf("ERR %0t: init %b irq %b berr %b, expected %b",
                                 $time, init, irq, berr, chk));
   endtask

   task automatic bus_step(input lsi_ctl_pkg::cmd_op_e op, input logic [15:0] adr,
                           input logic [15:0] dat, input logic drain,
                           input logic [5:0] p, input logic [4:0] chk);
      steps.push_back({op, lsi_ctl_pkg::CLR_INIT, adr, dat, drain, p, chk});
   endtask

   task automatic sys_step(input lsi_ctl_pkg::sys_code_e code, input logic [5:0] p,
                           input logic [4:0] chk);
      steps.push_back({lsi_ctl_pkg::OP_SYS, code, 16'h0000, 16'h0000, 1'b1, p, chk});
   endtask

   task automatic build_table();
      sys_step(lsi_ctl_pkg::CLR_INIT, 6'b000000, 5'b00000);
      sys_step(lsi_ctl_pkg::SET_INIT, 6'b000000, 5'b10000);
      sys_step(lsi_ctl_pkg::CLR_INIT, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_WRITE,  16'h0010, 16'h1234, 1'b0, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_WRITE,  16'h0012, 16'hABCD, 1'b0, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0010, 16'h0000, 1'b0, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0012, 16'h0000, 1'b0, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_WRBYTE, 16'h0011, 16'h5A00, 1'b0, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_WRBYTE, 16'h0012, 16'h00C3, 1'b0, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0010, 16'h0000, 1'b0, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0012, 16'h0000, 1'b0, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0020, 16'h0000, 1'b0, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_WRITE,  16'h007E, 16'h0F0F, 1'b0, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h007E, 16'h0000, 1'b1, 6'b000000, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h00F0, 16'h0000, 1'b1, 6'b000000, 5'b00001);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0010, 16'h0000, 1'b1, 6'b000000, 5'b00001);
      sys_step(lsi_ctl_pkg::CLR_BERR, 6'b000010, 5'b00000);
      sys_step(lsi_ctl_pkg::SET_FDIN, 6'b000010, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0012, 16'h0000, 1'b1, 6'b000010, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0012, 16'h0000, 1'b1, 6'b000010, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0010, 16'h0000, 1'b1, 6'b100010, 5'b01000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0012, 16'h0000, 1'b1, 6'b110010, 5'b01100);
      sys_step(lsi_ctl_pkg::CLR_ACLO, 6'b110010, 5'b00100);
      sys_step(lsi_ctl_pkg::SET_FDIN, 6'b110010, 5'b00100);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0010, 16'h0000, 1'b1, 6'b110010, 5'b00100);
      sys_step(lsi_ctl_pkg::CLR_EVNT, 6'b000010, 5'b00000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0012, 16'h0000, 1'b1, 6'b001010, 5'b01000);
      sys_step(lsi_ctl_pkg::SET_INIT, 6'b000110, 5'b10010);
      bus_step(lsi_ctl_pkg::OP_IAK,    16'h0000, 16'h01AC, 1'b1, 6'b000010, 5'b10000);
      bus_step(lsi_ctl_pkg::OP_WRITE,  16'h0030, 16'h7777, 1'b0, 6'b000010, 5'b10000);
      bus_step(lsi_ctl_pkg::OP_WRITE,  16'h0032, 16'h8888, 1'b0, 6'b000010, 5'b10000);
      bus_step(lsi_ctl_pkg::OP_WRBYTE, 16'h0031, 16'h1100, 1'b0, 6'b000010, 5'b10000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0030, 16'h0000, 1'b0, 6'b000010, 5'b10000);
      bus_step(lsi_ctl_pkg::OP_READ,   16'h0032, 16'h0000, 1'b0, 6'b000010, 5'b10000);
      bus_step(lsi_ctl_pkg::OP_IAK,    16'h0000, 16'h0100, 1'b1, 6'b000010, 5'b10000);
   endtask

   // works out the response, updates the models, sends on a credit
   task automatic send_step(input step_t s);
      logic [5:0]        idx;
      lsi_ctl_pkg::cmd_t c;
      lsi_ctl_pkg::rsp_t e;
      idx = s.adr[6:1];
      c   = '0;
      e   = '0;
      c.op = s.op;
      if (s.op == lsi_ctl_pkg::OP_SYS)
         c.payload.sys.code = s.code;
      else
         c.payload.bus = {s.adr, s.dat};
      while (credits == 0)
         tick();
      if (s.pins[5] & ~pins[5])
         aclo_rq_m = 1'b1;                            // aclo rising edge
      pins = s.pins;
      case (s.op)
         lsi_ctl_pkg::OP_READ:
         begin
            if (s.adr == 16'h00F0)
            begin
               e.berr = 1'b1;                         // hole never acks so the bus times out
               berr_m = 1'b1;
            end
            else
            begin
               e.dat = model[idx];
               if (fdin_m)
                  e.dat[3:0] = {pins[5] | aclo_rq_m, berr_m, pins[1:0]};
            end
            fdin_m = 1'b0;
         end
         lsi_ctl_pkg::OP_WRITE:
         begin
            model[idx] = s.dat;
            e.dat      = s.dat;
            fdin_m     = 1'b0;
         end
         lsi_ctl_pkg::OP_WRBYTE:
         begin
            if (s.adr[0])
               model[idx][15:8] = s.dat[15:8];        // odd address selects high byte
            else
               model[idx][7:0] = s.dat[7:0];
            e.dat  = s.dat;
            fdin_m = 1'b0;
         end
         lsi_ctl_pkg::OP_IAK:
         begin
            vector = s.dat;
            e.dat  = s.dat;
         end
         default:
         begin
            if (s.code == lsi_ctl_pkg::CLR_BERR)
               berr_m = 1'b0;
            if (s.code == lsi_ctl_pkg::SET_FDIN)
               fdin_m = 1'b1;
            if (s.code == lsi_ctl_pkg::CLR_ACLO)
               aclo_rq_m = 1'b0;
         end
      endcase
      credits--;
      cmd       = c;
      cmd_valid = 1'b1;
      exp_q.push_back(e);
      sent++;
      tick();
      cmd_valid = 1'b0;
      if (s.drain)
      begin
         while (exp_q.size() != 0)
            tick();
         repeat (2) tick();                           // edge detectors settle
         check_status(s.chk);
      end
   endtask

   // responses in command order
   always @(negedge vm_clk_p)
   begin
      if (rsp_valid)
      begin
         assert (exp_q.size() != 0)
            else fail_run("a response arrived with no command outstanding");
         exp_rsp = exp_q.pop_front();
         assert (rsp == exp_rsp)
            else fail_run($sformatf("ERR %0t: rsp dat %h berr %b, expected dat %h berr %b",
                                    $time, rsp.dat, rsp.berr, exp_rsp.dat, exp_rsp.berr));
      end
   end

   initial
   begin
      m_sr      = 1'b1;
      cmd_valid = 1'b0;
      cmd       = '0;
      wbm_gnt   = 1'b1;
      pins      = '0;
      vector    = '0;
      credits   = lsi_ctl_pkg::CMD_CREDITS;
      sent      = 0;
      returned  = 0;
      aclo_rq_m = 1'b0;
      berr_m    = 1'b0;
      fdin_m    = 1'b0;
      for (int i = 0; i < 64; i++)
         model[i] = {6'(i), 4'hA, 6'(i)};             // slave fill pattern
      build_table();
      repeat (8) @(negedge vm_clk_p);
      m_sr = 1'b0;
      tick();
      check_status(5'b10000);                         // INIT up after reset
      foreach (steps[i])
         send_step(steps[i]);
      while (exp_q.size() != 0)
         tick();
      repeat (2) tick();
      assert (returned == sent)
         else fail_run($sformatf("ERR %0t: %0d credits back for %0d commands",
                                 $time, returned, sent));
      $display("All tests passed");
      $finish;
   end

   // worst case every step runs into a bus timeout
   initial
   begin
      #1;
      repeat (steps.size() * (int'(lsi_bus_pkg::QTIM_MAX) + 20) + 16) @(posedge vm_clk_p);
      fail_run("timeout: the test sequence did not finish in time");
   end

endmodule

//--- tb_wb_slave.sv
// --------------------------------------------------
// Wishbone test slave
// 64-word memory with a random ack delay, a no-ack
// hole at 00F0 and an interrupt-vector responder
// --------------------------------------------------
`timescale 1ns/1ps

module tb_wb_slave
(
   input  logic                   vm_clk_p,           // system clock
   input  logic                   m_sr,               // async reset
   input  lsi_bus_pkg::wb_req_t   wbm_req_i,          // master bus request
   output lsi_bus_pkg::wb_rsp_t   wbm_rsp_o,          // master bus reply
   input  logic                   wbi_stb_i,          // vector strobe
   input  logic [15:0]            vec_i,              // vector to present
   output lsi_bus_pkg::vec_rsp_t  wbi_rsp_o           // vector reply
);

   logic [15:0] mem [64];                             // word storage
   integer      seed = 32'h3fee;                      // ack delay stream
   logic [2:0]  delay;                                // wait states this cycle
   logic [2:0]  wait_cnt;
   logic        vec_ack;
   logic [5:0]  widx;                                 // word index

   assign widx          = wbm_req_i.adr[6:1];
   assign wbm_rsp_o.ack = wbm_req_i.stb & (wbm_req_i.adr != 16'h00F0)
                        & (wait_cnt == delay);        // 00F0 never acks
   assign wbm_rsp_o.dat = mem[widx];
   assign wbi_rsp_o.ack = wbi_stb_i & vec_ack;        // one wait state
   assign wbi_rsp_o.dat = vec_i;

   always @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
      begin
         wait_cnt <= '0;
         delay    <= 3'd2;
         vec_ack  <= 1'b0;
         for (int i = 0; i < 64; i++)
            mem[i] <= {6'(i), 4'hA, 6'(i)};           // index in both bytes
      end
      else
      begin
         if (wbm_rsp_o.ack)
         begin
            wait_cnt <= '0;
            delay    <= 3'($unsigned($random(seed)) % 6);   // 0 to 5
            if (wbm_req_i.we & wbm_req_i.sel[0])
               mem[widx][7:0] <= wbm_req_i.dat[7:0];
            if (wbm_req_i.we & wbm_req_i.sel[1])
               mem[widx][15:8] <= wbm_req_i.dat[15:8];
         end
         else if (wbm_req_i.stb)
            wait_cnt <= wait_cnt + 1'b1;
         else
            wait_cnt <= '0;
         vec_ack <= wbi_stb_i & ~wbi_rsp_o.ack;
      end
   end

endmodule

//--- lsi_bus_top.sv
// --------------------------------------------------
// LSI-11 bus interface top
// Command queue, Wishbone bus master and system
// control joined behind the command port
// --------------------------------------------------
`timescale 1ns/1ps

module lsi_bus_top
(
   input  logic                   vm_clk_p,           // system clock
   input  logic                   m_sr,               // async reset
   input  logic                   cmd_valid_i,
   input  lsi_ctl_pkg::cmd_t      cmd_i,
   output logic                   credit_o,
   output logic                   rsp_valid_o,
   output lsi_ctl_pkg::rsp_t      rsp_o,
   input  logic                   wbm_gnt_i,
   output lsi_bus_pkg::wb_req_t   wbm_req_o,
   input  lsi_bus_pkg::wb_rsp_t   wbm_rsp_i,
   output logic                   wbi_stb_o,
   input  lsi_bus_pkg::vec_rsp_t  wbi_rsp_i,
   input  logic                   vm_aclo_i,
   input  logic                   vm_evnt_i,
   input  logic                   vm_halt_i,
   input  logic                   vm_virq_i,
   input  logic [1:0]             vm_bsel_i,
   output logic                   init_o,
   output logic [3:1]             irq_o,
   output logic                   berr_o
);

   logic                   q_valid;                   // queue head valid
   lsi_ctl_pkg::cmd_t      q_cmd;
   logic                   q_pop;
   logic                   sys_stb;
   lsi_ctl_pkg::sys_code_e sys_code;
   logic                   cyc_end;
   logic                   bus_busy;                  // timer enable
   logic                   fdin_st;
   logic [3:0]             fdin_nib;
   logic                   tmo;

   lsi_cmd_queue u_queue
   (
      .vm_clk_p    (vm_clk_p),
      .m_sr        (m_sr),
      .cmd_valid_i (cmd_valid_i),
      .cmd_i       (cmd_i),
      .q_pop_i     (q_pop),
      .q_valid_o   (q_valid),
      .q_cmd_o     (q_cmd),
      .credit_o    (credit_o)
   );

   lsi_bus_master u_master
   (
      .vm_clk_p    (vm_clk_p),
      .m_sr        (m_sr),
      .q_valid_i   (q_valid),
      .q_cmd_i     (q_cmd),
      .wbm_rsp_i   (wbm_rsp_i),
      .wbi_rsp_i   (wbi_rsp_i),
      .wbm_gnt_i   (wbm_gnt_i),
      .fdin_st_i   (fdin_st),
      .fdin_nib_i  (fdin_nib),
      .tmo_i       (tmo),
      .q_pop_o     (q_pop),
      .wbm_req_o   (wbm_req_o),
      .wbi_stb_o   (wbi_stb_o),
      .sys_stb_o   (sys_stb),
      .sys_code_o  (sys_code),
      .cyc_end_o   (cyc_end),
      .bus_busy_o  (bus_busy),
      .rsp_valid_o (rsp_valid_o),
      .rsp_o       (rsp_o)
   );

   lsi_sys_ctl u_sys
   (
      .vm_clk_p    (vm_clk_p),
      .m_sr        (m_sr),
      .sys_stb_i   (sys_stb),
      .sys_code_i  (sys_code),
      .cyc_end_i   (cyc_end),
      .bus_busy_i  (bus_busy),
      .vm_aclo_i   (vm_aclo_i),
      .vm_evnt_i   (vm_evnt_i),
      .vm_halt_i   (vm_halt_i),
      .vm_virq_i   (vm_virq_i),
      .vm_bsel_i   (vm_bsel_i),
      .init_o      (init_o),
      .irq_o       (irq_o),
      .fdin_st_o   (fdin_st),
      .fdin_nib_o  (fdin_nib),
      .tmo_o       (tmo),
      .berr_o      (berr_o)
   );

endmodule

//--- lsi_sys_ctl.sv
// --------------------------------------------------
// LSI-11 system control
// Power-fail and timer edge detectors, INIT, fast
// input flag, bus timer with sticky bus error and
// processor interrupt requests
// --------------------------------------------------
`timescale 1ns/1ps

module lsi_sys_ctl
(
   input  logic                    vm_clk_p,          // system clock
   input  logic                    m_sr,              // async reset
   input  logic                    sys_stb_i,         // system code strobe
   input  lsi_ctl_pkg::sys_code_e  sys_code_i,        // system code
   input  logic                    cyc_end_i,         // master cycle done
   input  logic                    bus_busy_i,        // strobe active
   input  logic                    vm_aclo_i,         // power fail
   input  logic                    vm_evnt_i,         // timer event
   input  logic                    vm_halt_i,         // halt request
   input  logic                    vm_virq_i,         // vectored irq
   input  logic [1:0]              vm_bsel_i,         // boot mode
   output logic                    init_o,            // peripheral INIT
   output logic [3:1]              irq_o,             // interrupt requests
   output logic                    fdin_st_o,         // fast input flag
   output logic [3:0]              fdin_nib_o,        // status nibble
   output logic                    tmo_o,             // bus timeout pulse
   output logic                    berr_o             // sticky bus error
);

   logic clr_init, clr_berr, set_init, set_fdin, clr_aclo, clr_evnt;
   logic aclo_ed;                                     // aclo edge detector
   logic evnt_ed;                                     // evnt edge detector
   logic aclo_rq;
   logic evnt_rq;
   logic init_st;
   logic fdin_st;
   logic berr_st;
   logic [lsi_bus_pkg::QTIM_W-1:0] qtim;              // bus timer

   assign clr_init = sys_stb_i & (sys_code_i == lsi_ctl_pkg::CLR_INIT);
   assign clr_berr = sys_stb_i & (sys_code_i == lsi_ctl_pkg::CLR_BERR);
   assign set_init = sys_stb_i & (sys_code_i == lsi_ctl_pkg::SET_INIT);
   assign set_fdin = sys_stb_i & (sys_code_i == lsi_ctl_pkg::SET_FDIN);
   assign clr_aclo = sys_stb_i & (sys_code_i == lsi_ctl_pkg::CLR_ACLO);
   assign clr_evnt = sys_stb_i & (sys_code_i == lsi_ctl_pkg::CLR_EVNT);

   assign tmo_o      = bus_busy_i & (qtim == lsi_bus_pkg::QTIM_MAX);
   assign init_o     = init_st;
   assign berr_o     = berr_st;
   assign fdin_st_o  = fdin_st;
   assign fdin_nib_o = {vm_aclo_i | aclo_rq, berr_st, vm_bsel_i};
   assign irq_o      = {aclo_rq | vm_halt_i, evnt_rq, vm_virq_i};

   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
      begin
         aclo_ed <= 1'b0;
         evnt_ed <= 1'b0;
         aclo_rq <= 1'b0;
         evnt_rq <= 1'b0;
         init_st <= 1'b1;                             // INIT held from reset
         fdin_st <= 1'b0;
         berr_st <= 1'b0;
      end
      else
      begin
         aclo_ed <= vm_aclo_i;
         evnt_ed <= vm_evnt_i;
         if (clr_aclo)
            aclo_rq <= 1'b0;
         else if (vm_aclo_i & ~aclo_ed)
            aclo_rq <= 1'b1;
         if (clr_evnt)
            evnt_rq <= 1'b0;
         else if (vm_evnt_i & ~evnt_ed)
            evnt_rq <= 1'b1;
         if (set_init)
            init_st <= 1'b1;
         else if (clr_init)
            init_st <= 1'b0;
         if (cyc_end_i)
            fdin_st <= 1'b0;                          // one read only
         else if (set_fdin)
            fdin_st <= 1'b1;
         if (clr_berr)
            berr_st <= 1'b0;
         else if (tmo_o)
            berr_st <= 1'b1;
      end
   end

   // runs while a strobe is out and holds at the limit
   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
         qtim <= '0;
      else if (~bus_busy_i)
         qtim <= '0;
      else if (qtim != lsi_bus_pkg::QTIM_MAX)
         qtim <= qtim + 1'b1;
   end

   // the master must drop its strobe right after a timeout
   a_tmo_busy: assert property (@(posedge vm_clk_p) disable iff (m_sr)
      tmo_o |=> ~bus_busy_i);

endmodule

//--- lsi_bus_master.sv
// --------------------------------------------------
// LSI-11 Wishbone bus master
// Runs one queued command at a time on the master
// bus, the vector bus or the system-control strobe,
// and returns one response word per command
// --------------------------------------------------
`timescale 1ns/1ps

module lsi_bus_master
(
   input  logic                    vm_clk_p,          // system clock
   input  logic                    m_sr,              // async reset
   input  logic                    q_valid_i,         // queue head valid
   input  lsi_ctl_pkg::cmd_t       q_cmd_i,           // queue head
   input  lsi_bus_pkg::wb_rsp_t    wbm_rsp_i,         // master bus reply
   input  lsi_bus_pkg::vec_rsp_t   wbi_rsp_i,         // vector bus reply
   input  logic                    wbm_gnt_i,         // master bus granted
   input  logic                    fdin_st_i,         // fast input pending
   input  logic [3:0]              fdin_nib_i,        // status nibble
   input  logic                    tmo_i,             // bus timeout
   output logic                    q_pop_o,           // take head entry
   output lsi_bus_pkg::wb_req_t    wbm_req_o,         // master bus request
   output logic                    wbi_stb_o,         // vector strobe
   output logic                    sys_stb_o,         // system code strobe
   output lsi_ctl_pkg::sys_code_e  sys_code_o,        // system code
   output logic                    cyc_end_o,         // master cycle done
   output logic                    bus_busy_o,        // timer enable
   output logic                    rsp_valid_o,       // response strobe
   output lsi_ctl_pkg::rsp_t       rsp_o              // response word
);

   typedef enum logic [2:0] {
      S_IDLE,                                         // wait for command
      S_BUS,                                          // master bus cycle
      S_VEC,                                          // vector fetch
      S_SYS,                                          // system strobe
      S_RSP                                           // response out
   } state_e;

   state_e                 state;
   lsi_bus_pkg::wb_req_t   req;
   lsi_ctl_pkg::rsp_t      rsp_q;
   lsi_ctl_pkg::sys_code_e code_q;
   lsi_ctl_pkg::cmd_op_e   op;
   logic                   is_bus;                    // needs master bus
   logic                   start;
   logic [1:0]             byte_sel;
   logic [15:0]            rd_dat;                    // read data after fdin merge

   assign op       = q_cmd_i.op;
   assign is_bus   = (op == lsi_ctl_pkg::OP_READ) | (op == lsi_ctl_pkg::OP_WRITE)
                   | (op == lsi_ctl_pkg::OP_WRBYTE);
   assign start    = (state == S_IDLE) & q_valid_i & (~is_bus | wbm_gnt_i);
   assign byte_sel = (op != lsi_ctl_pkg::OP_WRBYTE) ? lsi_bus_pkg::SEL_WORD
                   : q_cmd_i.payload.bus.adr[0] ? lsi_bus_pkg::SEL_HI : lsi_bus_pkg::SEL_LO;
   assign rd_dat   = fdin_st_i ? {wbm_rsp_i.dat[15:4], fdin_nib_i} : wbm_rsp_i.dat;

   assign q_pop_o     = start;
   assign wbm_req_o   = req;
   assign wbi_stb_o   = (state == S_VEC);
   assign sys_stb_o   = (state == S_SYS);
   assign sys_code_o  = code_q;
   assign cyc_end_o   = req.cyc & (wbm_rsp_i.ack | tmo_i);
   assign bus_busy_o  = req.stb | wbi_stb_o;
   assign rsp_valid_o = (state == S_RSP);
   assign rsp_o       = rsp_q;

   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
         state <= S_IDLE;
      else
         case (state)
            S_IDLE:
               if (start)
               begin
                  if (is_bus)
                     state <= S_BUS;
                  else if (op == lsi_ctl_pkg::OP_IAK)
                     state <= S_VEC;
                  else if (op == lsi_ctl_pkg::OP_SYS)
                     state <= S_SYS;
                  else
                     state <= S_RSP;                  // unknown op gets an empty reply
               end
            S_BUS:   if (wbm_rsp_i.ack | tmo_i) state <= S_RSP;
            S_VEC:   if (wbi_rsp_i.ack | tmo_i) state <= S_RSP;
            S_SYS:   state <= S_RSP;
            default: state <= S_IDLE;
         endcase
   end

   // cyc and stb rise together and fall on ack or timeout
   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
         req <= '0;
      else if (start & is_bus)
      begin
         req.adr <= q_cmd_i.payload.bus.adr;
         req.dat <= q_cmd_i.payload.bus.dat;
         req.sel <= byte_sel;
         req.we  <= (op != lsi_ctl_pkg::OP_READ);
         req.cyc <= 1'b1;
         req.stb <= 1'b1;
      end
      else if (req.stb & (wbm_rsp_i.ack | tmo_i))
      begin
         req.cyc <= 1'b0;
         req.stb <= 1'b0;
      end
   end

   always_ff @(posedge vm_clk_p)
   begin
      if (start)
         code_q <= q_cmd_i.payload.sys.code;
      case (state)
         S_IDLE:  rsp_q <= '0;                        // system reply stays zero
         S_BUS:
            if (wbm_rsp_i.ack)
               rsp_q <= {req.we ? req.dat : rd_dat, 1'b0};
            else if (tmo_i)
               rsp_q <= {16'h0000, 1'b1};
         S_VEC:
            if (wbi_rsp_i.ack)
               rsp_q <= {wbi_rsp_i.dat, 1'b0};
            else if (tmo_i)
               rsp_q <= {16'h0000, 1'b1};
         default: ;
      endcase
   end

   // cyc and stb open only in the bus state
   a_stb_cyc: assert property (@(posedge vm_clk_p) disable iff (m_sr)
      {wbm_req_o.cyc, wbm_req_o.stb} == {2{state == S_BUS}});

   // one reply pulse in the cycle after a master cycle ends
   a_rsp_single: assert property (@(posedge vm_clk_p) disable iff (m_sr)
      cyc_end_o |=> rsp_valid_o ##1 ~rsp_valid_o);

endmodule

//--- lsi_cmd_queue.sv
// --------------------------------------------------
// LSI-11 command queue
// Two-entry circular buffer between the command
// port and the bus master, one credit per pop
// --------------------------------------------------
`timescale 1ns/1ps

module lsi_cmd_queue
(
   input  logic               vm_clk_p,               // system clock
   input  logic               m_sr,                   // async reset
   input  logic               cmd_valid_i,            // push spending a credit
   input  lsi_ctl_pkg::cmd_t  cmd_i,                  // command word
   input  logic               q_pop_i,                // head taken by master
   output logic               q_valid_o,              // head valid
   output lsi_ctl_pkg::cmd_t  q_cmd_o,                // head entry
   output logic               credit_o                // credit returned
);

   lsi_ctl_pkg::cmd_t mem [lsi_ctl_pkg::CMD_CREDITS]; // entry storage
   logic [lsi_ctl_pkg::CMD_PTR_W-1:0] wr_ptr;
   logic [lsi_ctl_pkg::CMD_PTR_W-1:0] rd_ptr;
   logic [lsi_ctl_pkg::CMD_CNT_W-1:0] count;          // entries held

   assign q_valid_o = (count != '0);
   assign q_cmd_o   = mem[rd_ptr];
   assign credit_o  = q_pop_i & q_valid_o;            // one per handed entry

   always_ff @(posedge vm_clk_p)
   begin
      if (cmd_valid_i)
         mem[wr_ptr] <= cmd_i;
   end

   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (cmd_valid_i)
            wr_ptr <= (wr_ptr == lsi_ctl_pkg::CMD_PTR_LAST) ? '0 : wr_ptr + 1'b1;
         if (credit_o)
            rd_ptr <= (rd_ptr == lsi_ctl_pkg::CMD_PTR_LAST) ? '0 : rd_ptr + 1'b1;
         if (cmd_valid_i & ~credit_o)
            count <= count + 1'b1;
         else if (~cmd_valid_i & credit_o)
            count <= count - 1'b1;
      end
   end

   // push into a full queue with no pop in the same cycle
   a_no_overflow: assert property (@(posedge vm_clk_p) disable iff (m_sr)
      cmd_valid_i |-> (count < lsi_ctl_pkg::CMD_CREDITS) || credit_o);

   // master popped nothing
   a_no_underflow: assert property (@(posedge vm_clk_p) disable iff (m_sr)
      q_pop_i |-> q_valid_o);

endmodule

//--- lsi_ctl_pkg.sv
// --------------------------------------------------
// LSI-11 command package
// Processor-side command and response types, opcode
// and system-control code sets, queue credit count
// --------------------------------------------------
package lsi_ctl_pkg;

   localparam int CMD_CREDITS = 2;                        // queue depth = credits
   localparam int CMD_PTR_W   = $clog2(CMD_CREDITS);
   localparam int CMD_CNT_W   = $clog2(CMD_CREDITS + 1);
   localparam logic [CMD_PTR_W-1:0] CMD_PTR_LAST = CMD_PTR_W'(CMD_CREDITS - 1);

   typedef enum logic [2:0] {
      OP_READ   = 3'd0,                                   // word read
      OP_WRITE  = 3'd1,                                   // word write
      OP_WRBYTE = 3'd2,                                   // byte write, lane from adr[0]
      OP_IAK    = 3'd3,                                   // interrupt vector fetch
      OP_SYS    = 3'd4                                    // system control
   } cmd_op_e;

   // extra-bit strobe codes of the microcode word
   typedef enum logic [3:0] {
      CLR_INIT = 4'b1001,                                 // deassert INIT
      CLR_BERR = 4'b1010,                                 // clear bus error
      SET_INIT = 4'b1100,                                 // assert INIT
      SET_FDIN = 4'b1101,                                 // set fast input
      CLR_ACLO = 4'b1110,                                 // clear aclo request
      CLR_EVNT = 4'b1111                                  // clear evnt request
   } sys_code_e;

   typedef struct packed {
      logic [15:0] adr;
      logic [15:0] dat;
   } bus_view_t;

   typedef struct packed {
      sys_code_e   code;
      logic [27:0] pad;                                   // unused
   } sys_view_t;

   // payload decoded by opcode
   typedef union packed {
      bus_view_t bus;
      sys_view_t sys;
   } cmd_payload_u;

   typedef struct packed {
      cmd_op_e      op;
      cmd_payload_u payload;
   } cmd_t;

   typedef struct packed {
      logic [15:0] dat;                                   // read/write/vector data
      logic        berr;                                  // bus timeout
   } rsp_t;

endpackage

//--- lsi_bus_pkg.sv
// --------------------------------------------------
// LSI-11 bus package
// Wishbone request and reply types for the master
// bus and the interrupt-vector bus, byte selects and
// the bus-timeout length
// --------------------------------------------------
package lsi_bus_pkg;

   localparam int QTIM_W = 6;                             // bus timer width
   localparam logic [QTIM_W-1:0] QTIM_MAX = 6'd63;        // timeout count

   localparam logic [1:0] SEL_WORD = 2'b11;               // full word
   localparam logic [1:0] SEL_LO   = 2'b01;               // even byte
   localparam logic [1:0] SEL_HI   = 2'b10;               // odd byte

   // master bus request, all registered in the bus master
   typedef struct packed {
      logic [15:0] adr;                                   // byte address
      logic [15:0] dat;                                   // write data
      logic [1:0]  sel;                                   // byte lanes
      logic        cyc;                                   // cycle in progress
      logic        stb;                                   // strobe
      logic        we;                                    // write enable
   } wb_req_t;

   typedef struct packed {
      logic [15:0] dat;                                   // read data
      logic        ack;                                   // slave ack
   } wb_rsp_t;

   typedef struct packed {
      logic [15:0] dat;                                   // interrupt vector
      logic        ack;                                   // vector ack
   } vec_rsp_t;

endpackage
